/* source/mano_isa_pkg.sv */
package mano_isa_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int WORD_W = 16;
  localparam int ADDR_W = 12;
  localparam int CHAR_W = 8;
  localparam int OPC_W  = 3;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CHAR_W-1:0] char_t;
  typedef logic [OPC_W-1:0]  opcode_t;  // ir[14:12]

  localparam int MEM_WORDS = 4096;

  // ==================================================
  // opcodes and instruction bit fields
  // ==================================================
  localparam opcode_t OP_AND = 3'd0;
  localparam opcode_t OP_ADD = 3'd1;
  localparam opcode_t OP_LDA = 3'd2;
  localparam opcode_t OP_STA = 3'd3;
  localparam opcode_t OP_BUN = 3'd4;
  localparam opcode_t OP_BSA = 3'd5;
  localparam opcode_t OP_ISZ = 3'd6;
  localparam opcode_t OP_RIO = 3'd7;  // register or i/o group

  localparam int IND_BIT = 15;  // indirect, or i/o when opcode is 7

  // register-reference, one-hot in ir[11:0]
  localparam int RR_CLA = 11;
  localparam int RR_CLE = 10;
  localparam int RR_CMA = 9;
  localparam int RR_CME = 8;
  localparam int RR_CIR = 7;
  localparam int RR_CIL = 6;
  localparam int RR_INC = 5;
  localparam int RR_SPA = 4;
  localparam int RR_SNA = 3;
  localparam int RR_SZA = 2;
  localparam int RR_SZE = 1;
  localparam int RR_HLT = 0;

  // i/o group, top nibble F
  localparam int IO_INP = 11;
  localparam int IO_OUT = 10;
  localparam int IO_SKI = 9;
  localparam int IO_SKO = 8;

  typedef enum logic [3:0] {
    T_IDLE, T0, T1, T2, T3, T4, T5, T6, T7, T8, T9, T10
  } tstate_t;

endpackage

/* source/mano_bus_pkg.sv */
package mano_bus_pkg;

  // ==================================================
  // host apb map
  // ==================================================
  localparam int APB_ADDR_W = 16;
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;

  localparam int HOST_MEM_BIT = 12;  // set: memory, clear: i/o regs

  localparam int REG_OFF_W = 12;
  typedef logic [REG_OFF_W-1:0] reg_off_t;

  localparam reg_off_t REG_CTRL = 12'h000;
  localparam reg_off_t REG_KBD  = 12'h001;
  localparam reg_off_t REG_DISP = 12'h002;

  // control/status bits
  localparam int CTRL_RUN_BIT  = 0;
  localparam int CTRL_HALT_BIT = 1;

  localparam int FLAG_BIT = 8;  // fgi / fgo in kbd and disp reads

endpackage

/* source/mano_cpu.sv */
`timescale 1ns/1ps

module mano_cpu (
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  input  mano_isa_pkg::word_t mem_rdata,
  input  logic                fgi,
  input  logic                fgo,
  input  mano_isa_pkg::char_t kbd_char,
  output mano_isa_pkg::addr_t mem_addr,
  output mano_isa_pkg::word_t mem_wdata,
  output logic                mem_we,
  output logic                inp_ack,
  output logic                out_strobe,
  output mano_isa_pkg::char_t out_char,
  output logic                halted
);

  mano_isa_pkg::tstate_t t_state;
  mano_isa_pkg::tstate_t t_step;
  mano_isa_pkg::word_t   ac;
  mano_isa_pkg::word_t   dr;
  mano_isa_pkg::word_t   ir;
  mano_isa_pkg::addr_t   pc;
  mano_isa_pkg::addr_t   ar;
  mano_isa_pkg::opcode_t opcode;
  logic                  e;
  logic                  run_q;
  logic [7:0]            dec;
  logic                  reg_grp;
  logic                  io_grp;
  logic                  mem_grp;
  logic                  t3;
  logic                  x0;
  logic                  x1;
  logic                  x2;
  logic                  rr_skip;
  logic                  io_skip;
  logic                  hlt_exec;
  logic                  last_state;
  logic [16:0]           sum;

  // ==================================================
  // decode
  // ==================================================
  assign opcode  = ir[14:12];
  assign dec     = 8'b1 << opcode;  // 3-to-8
  assign reg_grp = dec[mano_isa_pkg::OP_RIO] & ~ir[mano_isa_pkg::IND_BIT];
  assign io_grp  = dec[mano_isa_pkg::OP_RIO] & ir[mano_isa_pkg::IND_BIT];
  assign mem_grp = ~dec[mano_isa_pkg::OP_RIO];

  // execute phases, direct T4..T6, indirect T8..T10 after pointer read in T7
  assign t3 = (t_state == mano_isa_pkg::T3);
  assign x0 = (t_state == mano_isa_pkg::T4) | (t_state == mano_isa_pkg::T8);
  assign x1 = (t_state == mano_isa_pkg::T5) | (t_state == mano_isa_pkg::T9);
  assign x2 = (t_state == mano_isa_pkg::T6) | (t_state == mano_isa_pkg::T10);

  assign rr_skip = reg_grp & ((ir[mano_isa_pkg::RR_SPA] & ~ac[15]) |
                              (ir[mano_isa_pkg::RR_SNA] & ac[15]) |
                              (ir[mano_isa_pkg::RR_SZA] & (ac == '0)) |
                              (ir[mano_isa_pkg::RR_SZE] & ~e));
  assign io_skip = io_grp & ((ir[mano_isa_pkg::IO_SKI] & fgi) |
                             (ir[mano_isa_pkg::IO_SKO] & fgo));

  assign hlt_exec = t3 & reg_grp & ir[mano_isa_pkg::RR_HLT];

  assign last_state = (t3 & ~mem_grp) |
                      (x0 & (dec[mano_isa_pkg::OP_STA] | dec[mano_isa_pkg::OP_BUN] |
                             dec[mano_isa_pkg::OP_BSA])) |
                      (x1 & (dec[mano_isa_pkg::OP_AND] | dec[mano_isa_pkg::OP_ADD] |
                             dec[mano_isa_pkg::OP_LDA])) |
                      (x2 & dec[mano_isa_pkg::OP_ISZ]);

  // ==================================================
  // timing sequencer
  // ==================================================
  always_comb begin
    case (t_state)
      mano_isa_pkg::T0: t_step = mano_isa_pkg::T1;
      mano_isa_pkg::T1: t_step = mano_isa_pkg::T2;
      mano_isa_pkg::T2: t_step = mano_isa_pkg::T3;
      mano_isa_pkg::T3: t_step = ir[mano_isa_pkg::IND_BIT] ? mano_isa_pkg::T7 : mano_isa_pkg::T4;
      mano_isa_pkg::T4: t_step = mano_isa_pkg::T5;
      mano_isa_pkg::T5: t_step = mano_isa_pkg::T6;
      mano_isa_pkg::T7: t_step = mano_isa_pkg::T8;
      mano_isa_pkg::T8: t_step = mano_isa_pkg::T9;
      mano_isa_pkg::T9: t_step = mano_isa_pkg::T10;
      default: t_step = mano_isa_pkg::T_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      t_state <= mano_isa_pkg::T_IDLE;
      run_q   <= 1'b0;
      halted  <= 1'b0;
    end else begin
      run_q <= run;
      if (t_state == mano_isa_pkg::T_IDLE) begin
        if (run && !halted) t_state <= mano_isa_pkg::T0;
      end else if (hlt_exec || (last_state && !run)) begin
        t_state <= mano_isa_pkg::T_IDLE;
      end else if (last_state) begin
        t_state <= mano_isa_pkg::T0;
      end else begin
        t_state <= t_step;
      end
      if (hlt_exec) halted <= 1'b1;
      else if (run && !run_q) halted <= 1'b0;  // restart
    end
  end

  // ==================================================
  // datapath
  // ==================================================
  assign sum = {1'b0, ac} + {1'b0, mem_rdata};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
      ar <= '0;
      ir <= '0;
      ac <= '0;
      e  <= 1'b0;
    end else begin
      if (t_state == mano_isa_pkg::T0) begin
        ar <= pc;
        pc <= pc + 1'b1;
      end
      if (t_state == mano_isa_pkg::T2) begin
        ir <= mem_rdata;
        ar <= mem_rdata[11:0];  // operand or pointer address
      end
      if (t_state == mano_isa_pkg::T7) ar <= mem_rdata[11:0];  // effective address

      if (t3 && (rr_skip || io_skip)) pc <= pc + 1'b1;
      if (x0 && dec[mano_isa_pkg::OP_BUN]) pc <= ar;
      if (x0 && dec[mano_isa_pkg::OP_BSA]) pc <= ar + 1'b1;
      if (x2 && dec[mano_isa_pkg::OP_ISZ] && (dr == '0)) pc <= pc + 1'b1;

      if (t3 && reg_grp) begin
        if (ir[mano_isa_pkg::RR_CLA]) ac <= '0;
        if (ir[mano_isa_pkg::RR_CLE]) e <= 1'b0;
        if (ir[mano_isa_pkg::RR_CMA]) ac <= ~ac;
        if (ir[mano_isa_pkg::RR_CME]) e <= ~e;
        if (ir[mano_isa_pkg::RR_CIR]) begin
          ac <= {e, ac[15:1]};
          e  <= ac[0];
        end
        if (ir[mano_isa_pkg::RR_CIL]) begin
          ac <= {ac[14:0], e};
          e  <= ac[15];
        end
        if (ir[mano_isa_pkg::RR_INC]) ac <= ac + 1'b1;
      end
      if (inp_ack) ac[7:0] <= kbd_char;

      if (x1) begin
        if (dec[mano_isa_pkg::OP_AND]) ac <= ac & mem_rdata;
        if (dec[mano_isa_pkg::OP_ADD]) {e, ac} <= sum;  // carry into e
        if (dec[mano_isa_pkg::OP_LDA]) ac <= mem_rdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (x1 && dec[mano_isa_pkg::OP_ISZ]) dr <= mem_rdata + 1'b1;
  end

  // ==================================================
  // memory and i/o strobes
  // ==================================================
  assign mem_addr = ar;
  assign mem_we   = (x0 & (dec[mano_isa_pkg::OP_STA] | dec[mano_isa_pkg::OP_BSA])) |
                    (x2 & dec[mano_isa_pkg::OP_ISZ]);

  always_comb begin
    if (dec[mano_isa_pkg::OP_BSA]) mem_wdata = {4'h0, pc};  // return address
    else if (dec[mano_isa_pkg::OP_ISZ]) mem_wdata = dr;
    else mem_wdata = ac;
  end

  assign inp_ack    = t3 & io_grp & ir[mano_isa_pkg::IO_INP] & fgi;
  assign out_strobe = t3 & io_grp & ir[mano_isa_pkg::IO_OUT];
  assign out_char   = ac[7:0];

endmodule

/* source/mano_ram.sv */
`timescale 1ns/1ps

module mano_ram (
  input  logic                clk,
  input  mano_isa_pkg::addr_t cpu_addr,
  input  mano_isa_pkg::word_t cpu_wdata,
  input  logic                cpu_we,
  input  mano_isa_pkg::addr_t host_addr,
  input  mano_isa_pkg::word_t host_wdata,
  input  logic                host_we,
  output mano_isa_pkg::word_t cpu_rdata,
  output mano_isa_pkg::word_t host_rdata
);

  mano_isa_pkg::word_t mem [mano_isa_pkg::MEM_WORDS];

  // both ports in one process, host is locked out while the cpu runs
  always_ff @(posedge clk) begin
    if (cpu_we) mem[cpu_addr] <= cpu_wdata;
    if (host_we) mem[host_addr] <= host_wdata;
    cpu_rdata  <= mem[cpu_addr];   // old data on write
    host_rdata <= mem[host_addr];
  end

endmodule

/* source/mano_host_apb.sv */
`timescale 1ns/1ps

module mano_host_apb (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  mano_bus_pkg::apb_addr_t paddr,
  input  mano_isa_pkg::word_t     pwdata,
  input  logic                    halted,
  input  logic                    inp_ack,
  input  logic                    out_strobe,
  input  mano_isa_pkg::char_t     out_char,
  input  mano_isa_pkg::word_t     ram_rdata,
  output mano_isa_pkg::word_t     prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    run,
  output logic                    fgi,
  output logic                    fgo,
  output mano_isa_pkg::char_t     kbd_char,
  output mano_isa_pkg::addr_t     ram_addr,
  output mano_isa_pkg::word_t     ram_wdata,
  output logic                    ram_we
);

  mano_bus_pkg::reg_off_t reg_off;
  mano_isa_pkg::char_t    disp_char;
  logic                   access;
  logic                   is_mem;
  logic                   reg_hit;
  logic                   wr_ctrl;
  logic                   wr_kbd;
  logic                   rd_disp;

  assign access  = psel & penable;
  assign is_mem  = paddr[mano_bus_pkg::HOST_MEM_BIT];
  assign reg_off = paddr[mano_bus_pkg::REG_OFF_W-1:0];
  assign reg_hit = (reg_off == mano_bus_pkg::REG_CTRL) |
                   (reg_off == mano_bus_pkg::REG_KBD) |
                   (reg_off == mano_bus_pkg::REG_DISP);

  assign wr_ctrl = access & pwrite & ~is_mem & (reg_off == mano_bus_pkg::REG_CTRL);
  assign wr_kbd  = access & pwrite & ~is_mem & (reg_off == mano_bus_pkg::REG_KBD);
  assign rd_disp = access & ~pwrite & ~is_mem & (reg_off == mano_bus_pkg::REG_DISP);

  // ==================================================
  // memory path, address live from the setup cycle
  // ==================================================
  assign ram_addr  = paddr[mano_isa_pkg::ADDR_W-1:0];
  assign ram_wdata = pwdata;
  assign ram_we    = access & pwrite & is_mem & ~run;

  assign pready  = 1'b1;
  assign pslverr = access & (is_mem ? run : ~reg_hit);

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (is_mem) begin
        if (!run) prdata = ram_rdata;
      end else begin
        case (reg_off)
          mano_bus_pkg::REG_CTRL: begin
            prdata[mano_bus_pkg::CTRL_RUN_BIT]  = run;
            prdata[mano_bus_pkg::CTRL_HALT_BIT] = halted;
          end
          mano_bus_pkg::REG_KBD: begin
            prdata[mano_bus_pkg::FLAG_BIT]           = fgi;
            prdata[mano_isa_pkg::CHAR_W-1:0] = kbd_char;
          end
          mano_bus_pkg::REG_DISP: begin
            prdata[mano_bus_pkg::FLAG_BIT]           = fgo;
            prdata[mano_isa_pkg::CHAR_W-1:0] = disp_char;
          end
          default: prdata = '0;
        endcase
      end
    end
  end

  // ==================================================
  // control, keyboard and display registers
  // ==================================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run <= 1'b0;
      fgi <= 1'b0;
      fgo <= 1'b1;  // display ready
    end else begin
      if (wr_ctrl) run <= pwdata[mano_bus_pkg::CTRL_RUN_BIT];
      if (wr_kbd) fgi <= 1'b1;  // new char wins over ack
      else if (inp_ack) fgi <= 1'b0;
      if (out_strobe) fgo <= 1'b0;
      else if (rd_disp) fgo <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_kbd) kbd_char <= pwdata[mano_isa_pkg::CHAR_W-1:0];
    if (out_strobe) disp_char <= out_char;
  end

endmodule

/* source/mano_computer.sv */
`timescale 1ns/1ps

module mano_computer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  mano_bus_pkg::apb_addr_t paddr,
  input  mano_isa_pkg::word_t     pwdata,
  output mano_isa_pkg::word_t     prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    halted
);

  logic                run;
  logic                fgi;
  logic                fgo;
  logic                inp_ack;
  logic                out_strobe;
  mano_isa_pkg::char_t kbd_char;
  mano_isa_pkg::char_t out_char;

  // cpu side of the ram
  mano_isa_pkg::addr_t cpu_addr;
  mano_isa_pkg::word_t cpu_wdata;
  mano_isa_pkg::word_t cpu_rdata;
  logic                cpu_we;

  // host side of the ram
  mano_isa_pkg::addr_t ram_addr;
  mano_isa_pkg::word_t ram_wdata;
  mano_isa_pkg::word_t ram_rdata;
  logic                ram_we;

  mano_cpu u_cpu (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .mem_rdata  (cpu_rdata),
    .fgi        (fgi),
    .fgo        (fgo),
    .kbd_char   (kbd_char),
    .mem_addr   (cpu_addr),
    .mem_wdata  (cpu_wdata),
    .mem_we     (cpu_we),
    .inp_ack    (inp_ack),
    .out_strobe (out_strobe),
    .out_char   (out_char),
    .halted     (halted)
  );

  mano_ram u_ram (
    .clk        (clk),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .cpu_we     (cpu_we),
    .host_addr  (ram_addr),
    .host_wdata (ram_wdata),
    .host_we    (ram_we),
    .cpu_rdata  (cpu_rdata),
    .host_rdata (ram_rdata)
  );

  mano_host_apb u_host_apb (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .halted     (halted),
    .inp_ack    (inp_ack),
    .out_strobe (out_strobe),
    .out_char   (out_char),
    .ram_rdata  (ram_rdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .run        (run),
    .fgi        (fgi),
    .fgo        (fgo),
    .kbd_char   (kbd_char),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata),
    .ram_we     (ram_we)
  );

endmodule

/* verif/mano_tb_tasks.svh */
`ifndef MANO_TB_TASKS_SVH
`define MANO_TB_TASKS_SVH

// ==================================================
// apb host transfers
// ==================================================
task automatic apb_write(input mano_bus_pkg::apb_addr_t addr, input mano_isa_pkg::word_t data,
                         output logic err);
  @(posedge clk);
  psel    <= 1'b1;  // setup
  penable <= 1'b0;
  pwrite  <= 1'b1;
  paddr   <= addr;
  pwdata  <= data;
  @(posedge clk);
  penable <= 1'b1;  // access
  @(negedge clk);
  err = pslverr;
  check_eq("apb write pready", 1, pready);
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic apb_read(input mano_bus_pkg::apb_addr_t addr, output mano_isa_pkg::word_t data,
                        output logic err);
  @(posedge clk);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= 1'b0;
  paddr   <= addr;
  @(posedge clk);
  penable <= 1'b1;
  @(negedge clk);
  data = prdata;
  err  = pslverr;
  check_eq("apb read pready", 1, pready);
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic check_eq(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
  if (expected !== actual) begin
    $display("FAILED %s expected %h actual %h", name, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end
endtask

// ==================================================
// memory and program helpers
// ==================================================
task automatic mem_write(input mano_isa_pkg::addr_t addr, input mano_isa_pkg::word_t data);
  logic err;
  apb_write(16'h1000 | addr, data, err);
  check_eq("host memory write error", 0, err);
endtask

task automatic mem_read(input mano_isa_pkg::addr_t addr, output mano_isa_pkg::word_t data);
  logic err;
  apb_read(16'h1000 | addr, data, err);
  check_eq("host memory read error", 0, err);
endtask

task automatic load_program();
  for (int i = 0; i < prog.size(); i++) begin
    mem_write(i[11:0], prog[i]);
  end
endtask

task automatic start_run();
  logic err;
  apb_write(mano_bus_pkg::REG_CTRL, 16'h0001, err);
  check_eq("run set error", 0, err);
  while (halted) @(negedge clk);  // halted drops once run rises
endtask

task automatic stop_run();
  logic err;
  while (!halted) @(negedge clk);
  apb_write(mano_bus_pkg::REG_CTRL, 16'h0000, err);
  check_eq("run clear error", 0, err);
endtask

task automatic run_until_halt();
  start_run();
  stop_run();
endtask

`endif

/* verif/mano_computer_tb.sv */
`timescale 1ns/1ps

module mano_computer_tb;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WATCHDOG_NS = (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;

  logic                    clk;
  logic                    rst;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  mano_bus_pkg::apb_addr_t paddr;
  mano_isa_pkg::word_t     pwdata;
  mano_isa_pkg::word_t     prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    halted;

  integer              seed = 32'hcc92;
  mano_isa_pkg::word_t prog[$];

  mano_computer u_mano_computer (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .halted  (halted)
  );

  `include "mano_tb_tasks.svh"

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==================================================
  // instruction encoding
  // ==================================================
  function automatic mano_isa_pkg::word_t mri(input logic [2:0] op, input logic ind,
                                               input logic [11:0] addr);
    return {ind, op, addr};
  endfunction

  function automatic mano_isa_pkg::word_t rri(input int bit_pos);
    return 16'h7000 | (16'h1 << bit_pos);
  endfunction

  function automatic mano_isa_pkg::word_t ioi(input int bit_pos);
    return 16'hf000 | (16'h1 << bit_pos);
  endfunction

  // {e, ac} after a circulate
  function automatic logic [16:0] rot_right(input logic e, input logic [15:0] a);
    return {a[0], e, a[15:1]};
  endfunction

  function automatic logic [16:0] rot_left(input logic e, input logic [15:0] a);
    return {a[15], a[14:0], e};
  endfunction

  function automatic logic [15:0] marker(input logic skip);
    return skip ? 16'h0000 : 16'h0001;  // marker isz runs only when not skipped
  endfunction

  // ==================================================
  // directed tests
  // ==================================================
  task automatic test_mem_ref();
    mano_isa_pkg::word_t a;
    mano_isa_pkg::word_t b;
    mano_isa_pkg::word_t c;
    mano_isa_pkg::word_t rd;
    logic [16:0]         sum;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    sum = {1'b0, a} + {1'b0, b};
    prog.delete();
    prog.push_back(mri(mano_isa_pkg::OP_LDA, 1'b0, 12'h080));
    prog.push_back(mri(mano_isa_pkg::OP_ADD, 1'b1, 12'h083));  // via pointer
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b0, 12'h090));
    prog.push_back(mri(mano_isa_pkg::OP_AND, 1'b0, 12'h082));
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b1, 12'h084));
    prog.push_back(rri(mano_isa_pkg::RR_CLA));
    prog.push_back(rri(mano_isa_pkg::RR_CIL));  // carry into bit 0
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b0, 12'h092));
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h0fe));
    load_program();
    mem_write(12'h080, a);
    mem_write(12'h081, b);
    mem_write(12'h082, c);
    mem_write(12'h083, 16'h0081);
    mem_write(12'h084, 16'h0091);
    run_until_halt();
    mem_read(12'h090, rd);
    check_eq("mem_ref sum", sum[15:0], rd);
    mem_read(12'h091, rd);
    check_eq("mem_ref and", sum[15:0] & c, rd);
    mem_read(12'h092, rd);
    check_eq("mem_ref carry", {15'h0, sum[16]}, rd);
  endtask

  task automatic test_register_ref();
    mano_isa_pkg::word_t r;
    mano_isa_pkg::word_t rd;
    logic [15:0]         exp_w [6];
    logic [16:0]         ea;
    r = $random(seed);
    ea = {1'b0, r};  // after CLE
    ea = rot_right(ea[16], ea[15:0]);
    exp_w[0] = ea[15:0];
    ea = rot_left(ea[16], ea[15:0]);
    ea = rot_left(ea[16], ea[15:0]);
    exp_w[1] = ea[15:0];
    ea[15:0] = ~ea[15:0];
    exp_w[2] = ea[15:0];
    ea[15:0] = ea[15:0] + 16'h1;
    exp_w[3] = ea[15:0];
    ea[16] = ~ea[16];
    ea = rot_right(ea[16], ea[15:0]);
    exp_w[4] = ea[15:0];
    ea = rot_left(ea[16], 16'h0000);
    exp_w[5] = ea[15:0];
    prog.delete();
    prog.push_back(mri(mano_isa_pkg::OP_LDA, 1'b0, 12'h080));
    prog.push_back(rri(mano_isa_pkg::RR_CLE));
    prog.push_back(rri(mano_isa_pkg::RR_CIR));
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b0, 12'h090));
    prog.push_back(rri(mano_isa_pkg::RR_CIL));
    prog.push_back(rri(mano_isa_pkg::RR_CIL));
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b0, 12'h091));
    prog.push_back(rri(mano_isa_pkg::RR_CMA));
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b0, 12'h092));
    prog.push_back(rri(mano_isa_pkg::RR_INC));
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b0, 12'h093));
    prog.push_back(rri(mano_isa_pkg::RR_CME));
    prog.push_back(rri(mano_isa_pkg::RR_CIR));
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b0, 12'h094));
    prog.push_back(rri(mano_isa_pkg::RR_CLA));
    prog.push_back(rri(mano_isa_pkg::RR_CIL));
    prog.push_back(mri(mano_isa_pkg::OP_STA, 1'b0, 12'h095));
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h0fe));
    load_program();
    mem_write(12'h080, r);
    run_until_halt();
    for (int i = 0; i < 6; i++) begin
      mem_read(12'h090 + i, rd);
      check_eq($sformatf("register_ref step %0d", i), exp_w[i], rd);
    end
  endtask

  task automatic test_branch_skip();
    mano_isa_pkg::word_t v;
    mano_isa_pkg::word_t w;
    mano_isa_pkg::word_t rd;
    logic [15:0]         n;
    logic [15:0]         exp_m [7];
    n = ($random(seed) & 16'h3) % 3 + 1;  // loop count 1..3
    v = ($random(seed) & 16'h7fff) | 16'h1;
    w = v | 16'h8000;
    exp_m[0] = marker(~v[15]);     // SPA
    exp_m[1] = marker(v[15]);      // SNA
    exp_m[2] = marker(v == 16'h0); // SZA
    exp_m[3] = marker(1'b1);       // SZA after CLA
    exp_m[4] = marker(1'b1);       // SZE after CLE
    exp_m[5] = marker(1'b0);       // SZE after CME
    exp_m[6] = marker(w[15]);      // SNA on negative
    prog.delete();
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h003));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h090));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h090));
    prog.push_back(mri(mano_isa_pkg::OP_BSA, 1'b0, 12'h020));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h093));  // loop body
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h080));
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h004));
    prog.push_back(mri(mano_isa_pkg::OP_LDA, 1'b0, 12'h082));
    prog.push_back(rri(mano_isa_pkg::RR_SPA));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h094));
    prog.push_back(rri(mano_isa_pkg::RR_SNA));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h095));
    prog.push_back(rri(mano_isa_pkg::RR_SZA));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h096));
    prog.push_back(rri(mano_isa_pkg::RR_CLA));
    prog.push_back(rri(mano_isa_pkg::RR_SZA));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h097));
    prog.push_back(rri(mano_isa_pkg::RR_CLE));
    prog.push_back(rri(mano_isa_pkg::RR_SZE));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h098));
    prog.push_back(rri(mano_isa_pkg::RR_CME));
    prog.push_back(rri(mano_isa_pkg::RR_SZE));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h099));
    prog.push_back(mri(mano_isa_pkg::OP_LDA, 1'b0, 12'h083));
    prog.push_back(rri(mano_isa_pkg::RR_SNA));
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h09a));
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h0fe));
    load_program();
    // subroutine with its return slot at 020
    mem_write(12'h020, 16'h0000);
    mem_write(12'h021, mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h091));
    mem_write(12'h022, mri(mano_isa_pkg::OP_BUN, 1'b1, 12'h020));
    mem_write(12'h080, -n);
    mem_write(12'h082, v);
    mem_write(12'h083, w);
    for (int i = 0; i <= 10; i++) begin
      mem_write(12'h090 + i, 16'h0000);
    end
    run_until_halt();
    mem_read(12'h090, rd);
    check_eq("branch_skip bun", 16'h0000, rd);
    mem_read(12'h091, rd);
    check_eq("branch_skip bsa call", 16'h0001, rd);
    mem_read(12'h020, rd);
    check_eq("branch_skip bsa return", 16'h0004, rd);
    mem_read(12'h093, rd);
    check_eq("branch_skip isz count", n, rd);
    mem_read(12'h080, rd);
    check_eq("branch_skip isz zero", 16'h0000, rd);
    for (int i = 0; i < 7; i++) begin
      mem_read(12'h094 + i, rd);
      check_eq($sformatf("branch_skip marker %0d", i), exp_m[i], rd);
    end
  endtask

  task automatic test_io();
    mano_isa_pkg::char_t k;
    mano_isa_pkg::char_t o;
    mano_isa_pkg::word_t rd;
    logic                err;
    k = $random(seed);
    o = k + 8'h1;
    prog.delete();
    prog.push_back(ioi(mano_isa_pkg::IO_SKI));  // poll keyboard
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h000));
    prog.push_back(rri(mano_isa_pkg::RR_CLA));
    prog.push_back(ioi(mano_isa_pkg::IO_INP));
    prog.push_back(rri(mano_isa_pkg::RR_INC));
    prog.push_back(ioi(mano_isa_pkg::IO_OUT));
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h0fe));
    load_program();
    apb_write(mano_bus_pkg::REG_KBD, {8'h00, k}, err);
    check_eq("io kbd write error", 0, err);
    apb_read(mano_bus_pkg::REG_KBD, rd, err);
    check_eq("io fgi set", {8'h01, k}, rd);
    run_until_halt();
    apb_read(mano_bus_pkg::REG_KBD, rd, err);
    check_eq("io fgi cleared", {8'h00, k}, rd);
    apb_read(mano_bus_pkg::REG_DISP, rd, err);
    check_eq("io display char", {8'h00, o}, rd);
    apb_read(mano_bus_pkg::REG_DISP, rd, err);
    check_eq("io fgo set after read", {8'h01, o}, rd);
  endtask

  task automatic test_host_lockout();
    mano_isa_pkg::word_t keep;
    mano_isa_pkg::word_t rd;
    logic                err;
    keep = $random(seed);
    prog.delete();
    prog.push_back(mri(mano_isa_pkg::OP_ISZ, 1'b0, 12'h080));  // busy loop
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h000));
    prog.push_back(mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h0fe));
    load_program();
    mem_write(12'h080, 16'hfff8);
    mem_write(12'h0a0, keep);
    start_run();
    apb_write(16'h10a0, ~keep, err);
    check_eq("lockout write error", 1, err);
    apb_read(16'h10a0, rd, err);
    check_eq("lockout read error", 1, err);
    check_eq("lockout read data", 16'h0000, rd);
    apb_read(16'h0005, rd, err);
    check_eq("unmapped offset error", 1, err);
    stop_run();
    mem_read(12'h0a0, rd);
    check_eq("lockout contents kept", keep, rd);
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    rst     <= 1'b1;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    // every program ends with BUN 0FE into this halt stub and restarts at 0FF
    mem_write(12'h0fe, rri(mano_isa_pkg::RR_HLT));
    mem_write(12'h0ff, mri(mano_isa_pkg::OP_BUN, 1'b0, 12'h000));
    test_mem_ref();
    test_register_ref();
    test_branch_skip();
    test_io();
    test_host_lockout();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired, the CPU did not halt in time");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

endmodule

/* mano_computer.f */
+incdir+verif
source/mano_isa_pkg.sv
source/mano_bus_pkg.sv
source/mano_cpu.sv
source/mano_ram.sv
source/mano_host_apb.sv
source/mano_computer.sv
verif/mano_computer_tb.sv
